//--- all.f
hdl/pattern_pkg.sv
hdl/spi_frame_receiver.sv
hdl/control_registers.sv
hdl/pattern_memory.sv
hdl/pattern_sequencer.sv
hdl/pattern_serializer.sv
hdl/pattern_generator_top.sv
testbench/pattern_checker.sv
testbench/pattern_generator_assertions.sv
testbench/pattern_generator_tb.sv

//--- Bender.yml
package:
  name: pattern_generator

sources:
  - files:
      - hdl/pattern_pkg.sv
      - hdl/spi_frame_receiver.sv
      - hdl/control_registers.sv
      - hdl/pattern_memory.sv
      - hdl/pattern_sequencer.sv
      - hdl/pattern_serializer.sv
      - hdl/pattern_generator_top.sv
  - target: test
    files:
      - testbench/pattern_checker.sv
      - testbench/pattern_generator_assertions.sv
      - testbench/pattern_generator_tb.sv

//--- testbench/pattern_generator_tb.sv
//----------------------------------------------------------------------------
// testbench for the pattern generator, drives SPI frames from a step table
// and lets pattern_checker compare the serial output with a reference image
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pattern_generator_tb;

	localparam int MAX_STEPS = 40;
	localparam int LONGEST_PATTERN = 12;

	logic clock_ro;
	logic reset4_word_clock;
	logic spi_sclk;
	logic spi_mosi;
	logic spi_ce0;
	logic spi_ce1;
	logic spi_miso;
	logic serial_out;
	logic frame_sync;
	logic armed;
	logic pass_start;
	pattern_pkg::byte_address_t expected_start;
	pattern_pkg::byte_address_t expected_end;
	int checker_errors;
	int bytes_checked;
	int errors;
	int step_count;
	int watchdog_limit;

	// step table of chip select, frame, expected read and what to do around it
	logic step_select [MAX_STEPS];
	pattern_pkg::command_t step_command [MAX_STEPS];
	pattern_pkg::spi_address_t step_address [MAX_STEPS];
	pattern_pkg::word_t step_data [MAX_STEPS];
	logic step_check [MAX_STEPS];
	pattern_pkg::word_t step_expected [MAX_STEPS];
	logic step_sync [MAX_STEPS];
	// 0 disarm before the step, 1 arm after it, 2 leave as is
	int step_arm [MAX_STEPS];
	int step_hold [MAX_STEPS];
	logic step_quiet [MAX_STEPS];

	pattern_generator_top pattern_generator_top_inst (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_ce0(spi_ce0), .spi_ce1(spi_ce1),
		.spi_miso(spi_miso), .serial_out(serial_out), .frame_sync(frame_sync)
	);

	pattern_checker playback_checker (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.serial_out(serial_out), .frame_sync(frame_sync), .armed(armed),
		.expected_start(expected_start), .expected_end(expected_end),
		.pass_start(pass_start), .error_count(checker_errors),
		.bytes_checked(bytes_checked)
	);

	initial begin
		clock_ro = 1'b0;
		forever #50 clock_ro = ~clock_ro;
	end

	task automatic add_step(input logic sel, input pattern_pkg::command_t cmd,
		input pattern_pkg::spi_address_t addr, input pattern_pkg::word_t data,
		input logic check, input pattern_pkg::word_t expected, input logic sync,
		input int arm, input int hold, input logic quiet);
		step_select[step_count] = sel;
		step_command[step_count] = cmd;
		step_address[step_count] = addr;
		step_data[step_count] = data;
		step_check[step_count] = check;
		step_expected[step_count] = expected;
		step_sync[step_count] = sync;
		step_arm[step_count] = arm;
		step_hold[step_count] = hold;
		step_quiet[step_count] = quiet;
		step_count++;
	endtask

	task automatic write_register(input pattern_pkg::spi_address_t addr,
		input pattern_pkg::word_t data, input logic sync,
		input int arm, input int hold, input logic quiet);
		add_step(1'b0, pattern_pkg::COMMAND_WRITE, addr, data, 1'b0, '0, sync, arm, hold,
			quiet);
	endtask

	task automatic build_table();
		pattern_pkg::word_t words [8];
		int i;
		step_count = 0;
		// register access on ce0
		write_register(0, 32'h0000_0123, 1'b0, 2, 0, 1'b0);
		add_step(1'b0, 8'h00, 16'd0, '0, 1'b1, 32'h0000_0123, 1'b0, 2, 0, 1'b0);
		write_register(1, 32'ha5a5_0077, 1'b0, 2, 0, 1'b0);
		add_step(1'b0, 8'h00, 16'd1, '0, 1'b1, 32'ha5a5_0077, 1'b0, 2, 0, 1'b0);
		write_register(5, 32'hffff_ffff, 1'b0, 2, 0, 1'b0);
		add_step(1'b0, 8'h00, 16'd5, '0, 1'b1, 32'h0, 1'b0, 2, 0, 1'b0);
		add_step(1'b0, 8'h02, 16'd0, 32'h0000_dead, 1'b0, '0, 1'b0, 2, 0, 1'b0);
		add_step(1'b0, 8'h00, 16'd0, '0, 1'b1, 32'h0000_0123, 1'b0, 2, 0, 1'b0);
		// pattern memory on ce1, bytes 0 to 31
		for (i = 0; i < 8; i++) begin
			words[i] = $urandom;
			playback_checker.image[4 * i] = words[i][31:24];
			playback_checker.image[4 * i + 1] = words[i][23:16];
			playback_checker.image[4 * i + 2] = words[i][15:8];
			playback_checker.image[4 * i + 3] = words[i][7:0];
			add_step(1'b1, pattern_pkg::COMMAND_WRITE, 16'(i), words[i], 1'b0, '0, 1'b0,
				2, 0, 1'b0);
		end
		for (i = 0; i < 8; i++) begin
			add_step(1'b1, 8'h00, 16'(i), '0, 1'b1, words[i], 1'b0, 2, 0, 1'b0);
		end
		// playback of 8..19
		write_register(0, 8, 1'b0, 2, 0, 1'b0);
		write_register(1, 20, 1'b0, 2, 0, 1'b0);
		write_register(2, 1, 1'b0, 1, 400, 1'b0);
		// range changes while playing
		write_register(0, 12, 1'b1, 2, 0, 1'b0);
		write_register(1, 16, 1'b1, 2, 300, 1'b0);
		write_register(0, 24, 1'b1, 2, 0, 1'b0);
		write_register(1, 4, 1'b1, 2, 200, 1'b0);
		// disable, then resume
		write_register(2, 0, 1'b0, 0, 100, 1'b1);
		write_register(0, 8, 1'b0, 2, 0, 1'b0);
		write_register(1, 20, 1'b0, 2, 50, 1'b0);
		write_register(2, 1, 1'b0, 1, 400, 1'b0);
	endtask

	// one 56-bit frame, 8 clocks per bit, returns the data field seen on miso
	task automatic spi_transfer(input logic sel, input pattern_pkg::command_t cmd,
		input pattern_pkg::spi_address_t addr, input pattern_pkg::word_t data,
		input logic sync, output pattern_pkg::word_t miso_word);
		logic [pattern_pkg::FRAME_BITS-1:0] frame;
		int i;
		frame = {cmd, addr, data};
		miso_word = '0;
		if (sel) begin
			spi_ce1 = 1'b0;
		end else begin
			spi_ce0 = 1'b0;
		end
		repeat (4) @(posedge clock_ro);
		#10;
		for (i = 0; i < pattern_pkg::FRAME_BITS; i++) begin
			spi_sclk = 1'b0;
			spi_mosi = frame[pattern_pkg::FRAME_BITS-1-i];
			repeat (4) @(posedge clock_ro);
			#10;
			if (i >= pattern_pkg::HEADER_BITS) begin
				miso_word = {miso_word[30:0], spi_miso};
			end
			spi_sclk = 1'b1;
			repeat (4) @(posedge clock_ro);
			#10;
		end
		spi_sclk = 1'b0;
		repeat (4) @(posedge clock_ro);
		#10;
		// close the frame just after a pass starts, far from the next wrap
		if (sync) begin
			do begin
				@(posedge clock_ro);
				#1;
			end while (!pass_start);
			#9;
		end
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		repeat (6) @(posedge clock_ro);
		#10;
	endtask

	task automatic watch_outputs(input int clocks, input logic quiet);
		repeat (clocks) begin
			@(posedge clock_ro);
			if (quiet && (serial_out !== 1'b0 || frame_sync !== 1'b0)) begin
				errors++;
				$display("FAIL t=%0t serial_out/frame_sync expected 0/0 got %b/%b",
					$time, serial_out, frame_sync);
			end
		end
		if (clocks > 0) begin
			#10;
		end
	endtask

	initial begin
		pattern_pkg::word_t miso_word;
		int s;
		void'($urandom(77));
		errors = 0;
		watchdog_limit = 0;
		armed = 1'b0;
		expected_start = '0;
		expected_end = '0;
		spi_sclk = 1'b0;
		spi_mosi = 1'b0;
		spi_ce0 = 1'b1;
		spi_ce1 = 1'b1;
		reset4_word_clock = 1'b1;
		build_table();
		watchdog_limit = step_count * 70 * 8 + 4 * LONGEST_PATTERN * 8;
		repeat (4) @(posedge clock_ro);
		#10;
		reset4_word_clock = 1'b0;
		watch_outputs(200, 1'b1);
		for (s = 0; s < step_count; s++) begin
			if (step_arm[s] == 0) begin
				armed = 1'b0;
			end
			spi_transfer(step_select[s], step_command[s], step_address[s], step_data[s],
				step_sync[s], miso_word);
			if (step_check[s] && miso_word !== step_expected[s]) begin
				errors++;
				$display("FAIL t=%0t spi_miso expected %h got %h",
					$time, step_expected[s], miso_word);
			end
			// track the playback range as the register bank holds it
			if (!step_select[s] && step_command[s] == pattern_pkg::COMMAND_WRITE) begin
				if (step_address[s][3:0] == pattern_pkg::REGISTER_START) begin
					expected_start = step_data[s][9:0];
				end else if (step_address[s][3:0] == pattern_pkg::REGISTER_END) begin
					expected_end = step_data[s][9:0];
				end
			end
			if (step_arm[s] == 1) begin
				armed = 1'b1;
			end
			watch_outputs(step_hold[s], step_quiet[s]);
		end
		if (bytes_checked < 50) begin
			errors++;
			$display("playback checker compared only %0d bytes", bytes_checked);
		end
		$display("errors: testbench %0d, checker %0d, bytes checked %0d",
			errors, checker_errors, bytes_checked);
		if (errors == 0 && checker_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (watchdog_limit > 0);
		repeat (watchdog_limit + 400) @(posedge clock_ro);
		$display("timeout: the test steps did not finish in time");
		$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/pattern_generator_assertions.sv
//----------------------------------------------------------------------------
// serializer timing properties, bound into every pattern_serializer
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pattern_generator_assertions (
	input wire logic clock_ro,
	input wire logic reset4_word_clock,
	input wire logic advance,
	input wire logic at_frame_start,
	input wire logic enable,
	input wire logic frame_sync
);

	// one pulse per byte
	assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		advance |=> !advance [*7] ##1 advance)
		else $error("advance is not a single pulse every 8 clocks");

	// sequencer only moves in the clock after advance
	assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		!$past(advance) |-> $stable(at_frame_start))
		else $error("frame start flag changed without an advance");

	// frame marker holds between advance pulses
	assert property (@(posedge clock_ro) disable iff (reset4_word_clock)
		!advance && $stable(enable) |-> $stable(frame_sync))
		else $error("frame_sync changed within a byte");

endmodule

bind pattern_serializer pattern_generator_assertions serializer_assertions (
	.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
	.advance(advance), .at_frame_start(at_frame_start), .enable(enable),
	.frame_sync(frame_sync)
);

`default_nettype wire

//--- testbench/pattern_checker.sv
//----------------------------------------------------------------------------
// playback checker, aligns on frame_sync and rebuilds bytes from serial_out
// compares each byte with the reference image at the address that the
// wrap rule predicts, start and end are supplied by the testbench
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pattern_checker (
	input wire logic clock_ro,
	input wire logic reset4_word_clock,
	input wire logic serial_out,
	input wire logic frame_sync,
	input wire logic armed,
	input wire pattern_pkg::byte_address_t expected_start,
	input wire pattern_pkg::byte_address_t expected_end,
	output logic pass_start,
	output int error_count,
	output int bytes_checked
);

	// filled by the testbench as memory words are written
	pattern_pkg::byte_t image [pattern_pkg::MEMORY_BYTES];

	logic aligned;
	logic sync_prev;
	int bit_index;
	pattern_pkg::byte_address_t model_address;
	pattern_pkg::byte_address_t next_address;
	pattern_pkg::byte_address_t start_latched;
	pattern_pkg::byte_address_t end_latched;
	pattern_pkg::byte_t byte_bits;
	logic sync_expected;

	initial begin
		aligned = 1'b0;
		sync_prev = 1'b0;
		bit_index = 0;
		error_count = 0;
		bytes_checked = 0;
		pass_start = 1'b0;
	end

	always @(posedge clock_ro) begin
		pass_start <= 1'b0;
		if (reset4_word_clock || !armed) begin
			aligned = 1'b0;
		end else begin
			// first byte of a pass starts on the rising frame_sync
			if (!aligned && frame_sync && !sync_prev) begin
				aligned = 1'b1;
				bit_index = 0;
				model_address = expected_start;
				start_latched = expected_start;
				end_latched = expected_end;
			end
			if (aligned) begin
				if (bit_index == 0) begin
					sync_expected = model_address == start_latched;
					if (frame_sync !== sync_expected) begin
						error_count++;
						$display("FAIL t=%0t frame_sync expected %b got %b",
							$time, sync_expected, frame_sync);
					end
					if (sync_expected) begin
						pass_start <= 1'b1;
					end
					// the sequencer decides the next address at this point
					if (end_latched <= start_latched
						|| model_address == end_latched - 1'b1) begin
						next_address = expected_start;
						start_latched = expected_start;
						end_latched = expected_end;
					end else begin
						next_address = model_address + 1'b1;
					end
				end
				byte_bits = {byte_bits[6:0], serial_out};
				if (bit_index == pattern_pkg::BITS_PER_BYTE - 1) begin
					bytes_checked++;
					if (byte_bits !== image[model_address]) begin
						error_count++;
						$display("FAIL t=%0t serial_out byte at %0d expected %h got %h",
							$time, model_address, image[model_address], byte_bits);
					end
					model_address = next_address;
					bit_index = 0;
				end else begin
					bit_index++;
				end
			end
		end
		sync_prev = frame_sync;
	end

endmodule

`default_nettype wire

//--- hdl/pattern_generator_top.sv
//----------------------------------------------------------------------------
// pattern generator top level, SPI ports to registers and memory,
// sequencer and serializer for playback, miso select by chip select
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pattern_generator_top (
	input wire logic clock_ro,
	input wire logic reset4_word_clock,
	input wire logic spi_sclk,
	input wire logic spi_mosi,
	input wire logic spi_ce0,
	input wire logic spi_ce1,
	output logic spi_miso,
	output logic serial_out,
	output logic frame_sync
);

	logic register_miso;
	logic memory_miso;
	pattern_pkg::spi_address_t register_address;
	pattern_pkg::spi_address_t memory_address;
	pattern_pkg::word_t register_write_data;
	pattern_pkg::word_t memory_write_data;
	pattern_pkg::word_t register_read_word;
	pattern_pkg::word_t memory_read_word;
	logic register_write_strobe;
	logic memory_write_strobe;
	pattern_pkg::byte_address_t start_address;
	pattern_pkg::byte_address_t end_address;
	pattern_pkg::byte_address_t play_address;
	pattern_pkg::byte_t play_byte;
	logic enable;
	logic advance;
	logic at_frame_start;

	//------------------------------------------------------------------------
	// SPI side
	//------------------------------------------------------------------------
	spi_frame_receiver register_port (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.sclk(spi_sclk), .mosi(spi_mosi), .chip_select(spi_ce0), .miso(register_miso),
		.command(), .address(register_address), .write_data(register_write_data),
		.write_strobe(register_write_strobe), .read_word(register_read_word),
		.header_done()
	);

	spi_frame_receiver memory_port (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.sclk(spi_sclk), .mosi(spi_mosi), .chip_select(spi_ce1), .miso(memory_miso),
		.command(), .address(memory_address), .write_data(memory_write_data),
		.write_strobe(memory_write_strobe), .read_word(memory_read_word),
		.header_done()
	);

	// ce1 low selects the memory port
	assign spi_miso = spi_ce1 ? register_miso : memory_miso;

	control_registers control_registers_inst (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.write_strobe(register_write_strobe), .address(register_address),
		.write_data(register_write_data), .read_word(register_read_word),
		.start_address(start_address), .end_address(end_address), .enable(enable)
	);

	//------------------------------------------------------------------------
	// playback
	//------------------------------------------------------------------------
	pattern_memory pattern_memory_inst (
		.clock_ro(clock_ro),
		.write_strobe(memory_write_strobe), .address(memory_address),
		.write_data(memory_write_data), .read_word(memory_read_word),
		.play_address(play_address), .play_byte(play_byte)
	);

	pattern_sequencer pattern_sequencer_inst (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.advance(advance), .start_address(start_address), .end_address(end_address),
		.play_address(play_address), .at_frame_start(at_frame_start)
	);

	pattern_serializer pattern_serializer_inst (
		.clock_ro(clock_ro), .reset4_word_clock(reset4_word_clock),
		.play_byte(play_byte), .at_frame_start(at_frame_start), .enable(enable),
		.advance(advance), .serial_out(serial_out), .frame_sync(frame_sync)
	);

endmodule

`default_nettype wire

//--- hdl/pattern_serializer.sv
//----------------------------------------------------------------------------
// byte serializer, MSB first at one bit per clock
// loads a byte every 8 clocks and pulses advance to fetch the next one
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pattern_serializer (
	input wire logic clock_ro,
	input wire logic reset4_word_clock,
	input wire pattern_pkg::byte_t play_byte,
	input wire logic at_frame_start,
	input wire logic enable,
	output logic advance,
	output logic serial_out,
	output logic frame_sync
);

	pattern_pkg::serializer_state_t state;
	logic [2:0] bit_count;
	logic load;
	logic frame_flag;
	pattern_pkg::byte_t shift_register;

	assign load = state == pattern_pkg::shifting && bit_count == '0;

	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			state <= pattern_pkg::idle;
			bit_count <= '0;
			advance <= 1'b0;
			frame_flag <= 1'b0;
		end else begin
			advance <= load;
			case (state)
				pattern_pkg::idle: state <= pattern_pkg::shifting;
				default: begin
					// wraps after BITS_PER_BYTE counts
					bit_count <= bit_count + 1'b1;
					if (load) begin
						frame_flag <= at_frame_start;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clock_ro) begin
		if (load) begin
			shift_register <= play_byte;
		end else begin
			shift_register <= {shift_register[pattern_pkg::BITS_PER_BYTE-2:0], 1'b0};
		end
	end

	// output gating
	assign serial_out = enable && shift_register[pattern_pkg::BITS_PER_BYTE-1];
	assign frame_sync = enable && frame_flag;

endmodule

`default_nettype wire

//--- hdl/pattern_sequencer.sv
//----------------------------------------------------------------------------
// byte address loop for playback, start up to one before end, then wrap
// start and end are sampled at reset and at each wrap only
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pattern_sequencer (
	input wire logic clock_ro,
	input wire logic reset4_word_clock,
	input wire logic advance,
	input wire pattern_pkg::byte_address_t start_address,
	input wire pattern_pkg::byte_address_t end_address,
	output pattern_pkg::byte_address_t play_address,
	output logic at_frame_start
);

	pattern_pkg::byte_address_t start_latched;
	pattern_pkg::byte_address_t end_latched;
	pattern_pkg::byte_address_t last_address;
	logic wrap;

	assign last_address = end_latched - 1'b1;

	// an empty or inverted range just repeats the start byte
	assign wrap = (end_latched <= start_latched) || (play_address == last_address);

	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			play_address <= start_address;
			start_latched <= start_address;
			end_latched <= end_address;
		end else if (advance) begin
			if (wrap) begin
				play_address <= start_address;
				start_latched <= start_address;
				end_latched <= end_address;
			end else begin
				play_address <= play_address + 1'b1;
			end
		end
	end

	assign at_frame_start = play_address == start_latched;

endmodule

`default_nettype wire

//--- hdl/pattern_memory.sv
//----------------------------------------------------------------------------
// pattern memory, 256 words of 32 bits written and read over SPI
// playback reads one byte per address, first byte sent sits in bits 31..24
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pattern_memory (
	input wire logic clock_ro,
	input wire logic write_strobe,
	input wire pattern_pkg::spi_address_t address,
	input wire pattern_pkg::word_t write_data,
	output pattern_pkg::word_t read_word,
	input wire pattern_pkg::byte_address_t play_address,
	output pattern_pkg::byte_t play_byte
);

	pattern_pkg::word_t memory [pattern_pkg::MEMORY_BYTES / 4];
	pattern_pkg::word_address_t spi_word_address;
	pattern_pkg::word_address_t play_word_address;
	pattern_pkg::word_t play_word;

	assign spi_word_address = address[7:0];
	assign play_word_address = play_address[9:2];

	always_ff @(posedge clock_ro) begin
		if (write_strobe) begin
			memory[spi_word_address] <= write_data;
		end
	end

	// SPI side, presented as soon as the header is in
	assign read_word = memory[spi_word_address];

	assign play_word = memory[play_word_address];

	// lane 0 is the most significant byte
	always_ff @(posedge clock_ro) begin
		case (play_address[1:0])
			2'd0: play_byte <= play_word[31:24];
			2'd1: play_byte <= play_word[23:16];
			2'd2: play_byte <= play_word[15:8];
			default: play_byte <= play_word[7:0];
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/control_registers.sv
//----------------------------------------------------------------------------
// start, end and control registers behind chip select 0
// written by the SPI write strobe, read back combinationally by address
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module control_registers (
	input wire logic clock_ro,
	input wire logic reset4_word_clock,
	input wire logic write_strobe,
	input wire pattern_pkg::spi_address_t address,
	input wire pattern_pkg::word_t write_data,
	output pattern_pkg::word_t read_word,
	output pattern_pkg::byte_address_t start_address,
	output pattern_pkg::byte_address_t end_address,
	output logic enable
);

	pattern_pkg::word_t start_register;
	pattern_pkg::word_t end_register;
	pattern_pkg::word_t control_register;

	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			start_register <= '0;
			end_register <= '0;
			control_register <= '0;
		end else if (write_strobe) begin
			case (address[3:0])
				pattern_pkg::REGISTER_START: start_register <= write_data;
				pattern_pkg::REGISTER_END: end_register <= write_data;
				pattern_pkg::REGISTER_CONTROL: control_register <= write_data;
				default: ;
			endcase
		end
	end

	// unmapped addresses read as zero
	always_comb begin
		case (address[3:0])
			pattern_pkg::REGISTER_START: read_word = start_register;
			pattern_pkg::REGISTER_END: read_word = end_register;
			pattern_pkg::REGISTER_CONTROL: read_word = control_register;
			default: read_word = '0;
		endcase
	end

	assign start_address = start_register[9:0];
	assign end_address = end_register[9:0];
	// bit 0 is the output enable
	assign enable = control_register[0];

endmodule

`default_nettype wire

//--- hdl/spi_frame_receiver.sv
//----------------------------------------------------------------------------
// oversampled SPI slave for one chip select, 56-bit frames
// command, address and data arrive MSB first; read data goes out on miso
// during the data field, write_strobe marks a complete write frame
//----------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_frame_receiver (
	input wire logic clock_ro,
	input wire logic reset4_word_clock,
	input wire logic sclk,
	input wire logic mosi,
	input wire logic chip_select,
	output logic miso,
	output pattern_pkg::command_t command,
	output pattern_pkg::spi_address_t address,
	output pattern_pkg::word_t write_data,
	output logic write_strobe,
	input wire pattern_pkg::word_t read_word,
	output logic header_done
);

	logic [2:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic [2:0] select_sync;
	logic sclk_rise;
	logic sclk_fall;
	logic select_active;
	logic select_rise;
	logic data_phase;
	// saturates at all ones, so overlong frames never match
	logic [5:0] bit_count;
	pattern_pkg::word_t frame_shift;
	pattern_pkg::word_t frame_next;
	pattern_pkg::word_t miso_shift;

	//------------------------------------------------------------------------
	// pin synchronizers and edge detect
	//------------------------------------------------------------------------
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			sclk_sync <= '0;
			mosi_sync <= '0;
			select_sync <= '1;
		end else begin
			sclk_sync <= {sclk_sync[1:0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
			select_sync <= {select_sync[1:0], chip_select};
		end
	end

	assign sclk_rise = sclk_sync[2:1] == 2'b01;
	assign sclk_fall = sclk_sync[2:1] == 2'b10;
	assign select_active = !select_sync[1];
	assign select_rise = select_sync[2:1] == 2'b01;
	assign data_phase = bit_count >= pattern_pkg::HEADER_BITS;
	assign frame_next = {frame_shift[30:0], mosi_sync[1]};

	//------------------------------------------------------------------------
	// bit count, header capture, write strobe
	//------------------------------------------------------------------------
	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			bit_count <= '0;
			command <= '0;
			address <= '0;
			header_done <= 1'b0;
			write_strobe <= 1'b0;
		end else begin
			header_done <= 1'b0;
			write_strobe <= 1'b0;
			if (!select_active) begin
				bit_count <= '0;
				write_strobe <= select_rise && bit_count == pattern_pkg::FRAME_BITS
					&& command == pattern_pkg::COMMAND_WRITE;
			end else if (sclk_rise) begin
				if (bit_count != '1) begin
					bit_count <= bit_count + 1'b1;
				end
				// last header bit is arriving now
				if (bit_count == pattern_pkg::HEADER_BITS - 1) begin
					command <= frame_next[23:16];
					address <= frame_next[15:0];
					header_done <= 1'b1;
				end
			end
		end
	end

	// the last 32 bits in are the data field
	always_ff @(posedge clock_ro) begin
		if (select_active && sclk_rise) begin
			frame_shift <= frame_next;
		end
	end

	assign write_data = frame_shift;

	//------------------------------------------------------------------------
	// read data, one bit per sclk falling edge
	//------------------------------------------------------------------------
	always_ff @(posedge clock_ro) begin
		if (header_done) begin
			miso_shift <= read_word;
		end else if (sclk_fall && data_phase) begin
			miso_shift <= {miso_shift[30:0], 1'b0};
		end
	end

	always_ff @(posedge clock_ro) begin
		if (reset4_word_clock) begin
			miso <= 1'b0;
		end else if (!select_active) begin
			miso <= 1'b0;
		end else if (sclk_fall && data_phase) begin
			miso <= miso_shift[31];
		end
	end

endmodule

`default_nettype wire

//--- hdl/pattern_pkg.sv
//----------------------------------------------------------------------------
// shared widths, SPI commands and register map for the pattern generator
// every design file refers to these by pattern_pkg:: scoped names
//----------------------------------------------------------------------------

`default_nettype none

package pattern_pkg;

	// SPI frame fields
	typedef logic [7:0] command_t;
	typedef logic [15:0] spi_address_t;
	typedef logic [31:0] word_t;

	// pattern memory addressing
	typedef logic [7:0] byte_t;
	typedef logic [9:0] byte_address_t;
	typedef logic [7:0] word_address_t;

	// command byte, then 16-bit address, then 32-bit data
	localparam int FRAME_BITS = 56;
	localparam int HEADER_BITS = 24;
	localparam command_t COMMAND_WRITE = 8'h01;

	localparam int MEMORY_BYTES = 1024;
	localparam int BITS_PER_BYTE = 8;

	// control register map, decoded from address bits 3..0
	localparam logic [3:0] REGISTER_START = 4'd0;
	localparam logic [3:0] REGISTER_END = 4'd1;
	localparam logic [3:0] REGISTER_CONTROL = 4'd2;

	typedef enum logic {
		idle,
		shifting
	} serializer_state_t;

endpackage

`default_nettype wire
